// File: verilog.f
source/audio_pkg.sv
source/source_scaler.sv
source/mix_clamp.sv
source/output_leveler.sv
source/audio_mixer_top.sv
bench/tb_audio_mixer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the audio mixer testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_audio_mixer -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: bench/tb_audio_mixer.sv
// Directed testbench for the audio output path
// Streams frames into the mixer and checks every output against a reference model
`default_nettype none
`timescale 1ns/100ps

module tb_audio_mixer;

	import audio_pkg::*;

	// About 240 frames plus reset, idle time and a drain per test fit well inside
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int LATENCY        = 8;

	logic           clk_sys;
	logic           reset;
	logic           in_stb;
	audio_sources_t sources;
	mix_settings_t  settings;
	logic           out_stb;
	stereo_t        out;

	integer  seed      = 32'he1f0_d36c;
	int      cycle_cnt = 0;
	int      errors    = 0;
	int      checks    = 0;
	string   test_name = "reset";
	stereo_t exp_q[$];
	int      due_q[$];
	string   name_q[$];
	stereo_t exp_v;
	int      due_v;
	string   name_v;

	audio_mixer_top u_dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.in_stb   (in_stb),
		.sources  (sources),
		.settings (settings),
		.out_stb  (out_stb),
		.out      (out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////
	// Reference model
	////////////////////

	// Code zero mutes and any other code drops 15 minus its upper four bits
	function automatic int level(int s, logic [4:0] code);
		if (code == 5'd0)
			return 0;
		return s >>> (15 - int'(code[4:1]));
	endfunction

	function automatic int knee(int f, int a);
		return (32767 * (f - 1)) / (f * a - 1) + 1;
	endfunction

	function automatic int shape(int v, int f, int a);
		if (v < knee(f, a))
			return (v * a) & 32'h0000_ffff;
		return ((v - knee(f, a)) / f + knee(f, a) * a) & 32'h0000_ffff;
	endfunction

	function automatic sample_t side(audio_sources_t src, mix_settings_t set, logic right);
		int                 sb_v;
		int                 cd_v;
		int                 midi_v;
		int                 spk_v;
		int                 sum_v;
		int                 shaped;
		logic [4:0]         midi_code;
		logic               line_on;
		logic signed [16:0] sum17;
		sample_t            signed_v;

		sb_v    = right ? int'(src.sb.right) : int'(src.sb.left);
		cd_v    = right ? int'(src.cd.right) : int'(src.cd.left);
		midi_v  = right ? int'(src.midi.right) : int'(src.midi.left);
		line_on = right ? set.line_en_r : set.line_en_l;
		if (set.midi_from_line)
			midi_code = line_on ? (right ? set.vol_line_r : set.vol_line_l) : 5'd0;
		else
			midi_code = right ? set.vol_midi_r : set.vol_midi_l;
		midi_v = set.midi_mute ? 0 : level(midi_v, midi_code);
		if (right)
			cd_v = set.cd_en_r ? level(cd_v, set.vol_cd_r) : 0;
		else
			cd_v = set.cd_en_l ? level(cd_v, set.vol_cd_l) : 0;
		spk_v = 0;
		if (src.speaker)
			spk_v = (1 << (11 + int'(set.spk_boost))) >> (3 - int'(set.vol_spk));
		// The adder is 17 bits wide and the result clamps to 16
		sum17 = 17'(sb_v + cd_v + midi_v + spk_v);
		sum_v = int'(sum17);
		if (sum_v > 32767)
			sum_v = 32767;
		else if (sum_v < -32768)
			sum_v = -32768;
		shaped = (sum_v < 0) ? -sum_v : sum_v;
		if (set.boost == BOOST_2X)
			shaped = shape(shaped, 4, 2);
		else if (set.boost != BOOST_NONE)
			shaped = shape(shaped, 8, 4);
		signed_v = sample_t'((sum_v < 0) ? -shaped : shaped);
		return sample_t'(level(int'(signed_v), right ? set.vol_master_r : set.vol_master_l));
	endfunction

	function automatic mix_settings_t base_settings();
		mix_settings_t s;
		s              = '0;
		s.vol_master_l = 5'd31;
		s.vol_master_r = 5'd31;
		s.boost        = BOOST_NONE;
		return s;
	endfunction

	function automatic sample_t rand_sample();
		return sample_t'($random(seed));
	endfunction

	////////////////////
	// Drivers
	////////////////////

	// Starts 2 ns after a rising edge and returns at the same point one cycle later
	task automatic drive_frame(audio_sources_t src, mix_settings_t set);
		stereo_t r;
		r.left   = side(src, set, 1'b0);
		r.right  = side(src, set, 1'b1);
		sources  = src;
		settings = set;
		in_stb   = 1'b1;
		exp_q.push_back(r);
		due_q.push_back(cycle_cnt + LATENCY);
		name_q.push_back(test_name);
		@(posedge clk_sys);
		#2;
		in_stb = 1'b0;
	endtask

	task automatic drive_sb_cd(int sb_l, int sb_r, int cd_l, int cd_r, mix_settings_t set);
		audio_sources_t src;
		src          = '0;
		src.sb.left  = sample_t'(sb_l);
		src.sb.right = sample_t'(sb_r);
		src.cd.left  = sample_t'(cd_l);
		src.cd.right = sample_t'(cd_r);
		drive_frame(src, set);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk_sys);
		#2;
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic idle_and_speaker();
		audio_sources_t src;
		mix_settings_t  set;
		test_name = "idle_and_speaker";
		// The monitor flags any stray out_stb during these idle cycles
		repeat (10) @(posedge clk_sys);
		#2;
		src = '0;
		set = base_settings();
		drive_frame(src, set);
		src.speaker = 1'b1;
		for (int b = 0; b < 4; b++) begin
			for (int v = 0; v < 4; v++) begin
				set.spk_boost = b[1:0];
				set.vol_spk   = v[1:0];
				drive_frame(src, set);
			end
		end
		wait_drain();
	endtask

	task automatic sweep_source_levels();
		audio_sources_t src;
		mix_settings_t  set;
		test_name = "source_levels";
		src = '0;
		set = base_settings();
		for (int en = 0; en < 2; en++) begin
			for (int c = 0; c < 32; c++) begin
				src.cd.left  = rand_sample();
				src.cd.right = rand_sample();
				set.vol_cd_l = c[4:0];
				set.vol_cd_r = 5'(31 - c);
				set.cd_en_l  = en[0];
				set.cd_en_r  = en[0];
				drive_frame(src, set);
			end
		end
		src.cd = '0;
		set    = base_settings();
		// Mode 0 own volume, 1 line enabled, 2 line disabled, 3 muted
		for (int m = 0; m < 4; m++) begin
			for (int c = 0; c < 32; c++) begin
				src.midi.left      = rand_sample();
				src.midi.right     = rand_sample();
				set.vol_midi_l     = c[4:0];
				set.vol_midi_r     = 5'(31 - c);
				set.vol_line_l     = 5'(31 - c);
				set.vol_line_r     = c[4:0];
				set.midi_from_line = (m == 1 || m == 2);
				set.line_en_l      = (m == 1);
				set.line_en_r      = (m == 1);
				set.midi_mute      = (m == 3);
				drive_frame(src, set);
			end
		end
		wait_drain();
	endtask

	task automatic clamp_full_scale();
		mix_settings_t set;
		test_name    = "full_scale";
		set          = base_settings();
		set.cd_en_l  = 1'b1;
		set.cd_en_r  = 1'b1;
		set.vol_cd_l = 5'd31;
		set.vol_cd_r = 5'd31;
		drive_sb_cd(30000, 30000, 30000, 30000, set);
		drive_sb_cd(-30000, -30000, -30000, -30000, set);
		drive_sb_cd(32767, -32768, 32767, -32768, set);
		drive_sb_cd(20000, -20000, 12000, -12768, set);
		wait_drain();
	endtask

	task automatic compress_around_knees();
		mix_settings_t set;
		int            k;
		test_name = "knees";
		// Mode 3 is undefined and should behave as 4x
		for (int m = 1; m < 4; m++) begin
			set       = base_settings();
			set.boost = boost_mode_t'(m[1:0]);
			k         = (m == 1) ? knee(4, 2) : knee(8, 4);
			drive_sb_cd(100, -100, 0, 0, set);
			drive_sb_cd(k - 1, -(k - 1), 0, 0, set);
			drive_sb_cd(-k, k, 0, 0, set);
			drive_sb_cd(k + 1, -(k + 1), 0, 0, set);
			drive_sb_cd(-(k + 5000), k + 5000, 0, 0, set);
		end
		wait_drain();
	endtask

	task automatic burst_frames();
		audio_sources_t src;
		mix_settings_t  set;
		logic [63:0]    rbits;
		test_name = "burst";
		for (int i = 0; i < 10; i++) begin
			rbits = {$random(seed), $random(seed)};
			set   = rbits[57:0];
			if (i == 3) begin
				set.vol_master_l = 5'd0;
				set.vol_master_r = 5'd0;
			end
			src.sb.left    = rand_sample();
			src.sb.right   = rand_sample();
			src.cd.left    = rand_sample();
			src.cd.right   = rand_sample();
			src.midi.left  = rand_sample();
			src.midi.right = rand_sample();
			src.speaker    = rbits[63];
			drive_frame(src, set);
		end
		wait_drain();
	endtask

	////////////////////
	// Output monitor
	////////////////////

	always @(posedge clk_sys) begin
		#1;
		cycle_cnt = cycle_cnt + 1;
		if (out_stb === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("out_stb went high at cycle %0d with no frame pending", cycle_cnt);
			end else begin
				exp_v  = exp_q.pop_front();
				due_v  = due_q.pop_front();
				name_v = name_q.pop_front();
				checks++;
				if (due_v != cycle_cnt) begin
					errors++;
					$display("%s: out_stb came at cycle %0d instead of cycle %0d",
						name_v, cycle_cnt, due_v);
				end
				if (out !== exp_v) begin
					errors++;
					$display("error %s: expected L=%0d R=%0d, actual L=%0d R=%0d",
						name_v, exp_v.left, exp_v.right, out.left, out.right);
				end
			end
		end else if (out_stb !== 1'b0) begin
			errors++;
			$display("out_stb is unknown at cycle %0d", cycle_cnt);
		end else if (due_q.size() != 0 && due_q[0] <= cycle_cnt) begin
			errors++;
			$display("%s: no out_stb at cycle %0d for a pending frame", name_q[0], cycle_cnt);
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
			void'(name_q.pop_front());
		end
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES)
			@(posedge clk_sys);
		$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		reset    = 1'b1;
		in_stb   = 1'b0;
		sources  = '0;
		settings = '0;
		repeat (5) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		idle_and_speaker();
		sweep_source_levels();
		clamp_full_scale();
		compress_around_knees();
		burst_frames();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/audio_mixer_top.sv
// Top level of the audio output path
// Takes one frame per in_stb and delivers it on out_stb eight cycles later
`default_nettype none
`timescale 1ns/100ps

module audio_mixer_top #(
	// Compressor curve 1 (2x boost)
	parameter logic [3:0] COMP_F1 = 4'd4,
	parameter logic [3:0] COMP_A1 = 4'd2,
	// Compressor curve 2 (4x boost)
	parameter logic [3:0] COMP_F2 = 4'd8,
	parameter logic [3:0] COMP_A2 = 4'd4
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     in_stb,
	input  audio_pkg::audio_sources_t sources,
	input  audio_pkg::mix_settings_t  settings,
	output logic                     out_stb,
	output audio_pkg::stereo_t        out
);

	import audio_pkg::*;

	scaled_beat_t scaled;
	mixed_beat_t  mixed;

	////////////////////
	// Per-source scaling in one cycle
	////////////////////

	source_scaler u_source_scaler (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.in_stb   (in_stb),
		.sources  (sources),
		.settings (settings),
		.beat     (scaled)
	);

	////////////////////
	// Sum and saturate over two cycles
	////////////////////

	mix_clamp u_mix_clamp (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.beat_in  (scaled),
		.beat_out (mixed)
	);

	////////////////////
	// Compressor and master volume over five cycles
	////////////////////

	output_leveler #(
		.COMP_F1 (COMP_F1),
		.COMP_A1 (COMP_A1),
		.COMP_F2 (COMP_F2),
		.COMP_A2 (COMP_A2)
	) u_output_leveler (
		.clk_sys (clk_sys),
		.reset   (reset),
		.beat_in (mixed),
		.out_stb (out_stb),
		.out     (out)
	);

endmodule

`default_nettype wire

// File: source/output_leveler.sv
// Final pipeline stage with an optional two-curve compressor and then master volume
// Five cycles from beat_in to out_stb
`default_nettype none
`timescale 1ns/100ps

module output_leveler #(
	parameter logic [3:0] COMP_F1 = 4'd4,
	parameter logic [3:0] COMP_A1 = 4'd2,
	parameter logic [3:0] COMP_F2 = 4'd8,
	parameter logic [3:0] COMP_A2 = 4'd4
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  audio_pkg::mixed_beat_t beat_in,
	output logic                   out_stb,
	output audio_pkg::stereo_t     out
);

	import audio_pkg::*;

	// Knee is one above the exact crossing point and the offset is the gain at the knee
	localparam int COMP_X1 = ((32767 * (COMP_F1 - 1)) / ((COMP_F1 * COMP_A1) - 1)) + 1;
	localparam int COMP_B1 = COMP_X1 * COMP_A1;
	localparam int COMP_X2 = ((32767 * (COMP_F2 - 1)) / ((COMP_F2 * COMP_A2) - 1)) + 1;
	localparam int COMP_B2 = COMP_X2 * COMP_A2;

	// Settings that ride along with the frame
	typedef struct packed {
		boost_mode_t boost;
		vol_t        vol_l;
		vol_t        vol_r;
		logic [1:0]  sign;
	} ctl_t;

	sample_t     in_ch   [2];
	logic [15:0] mag_q   [2];
	logic [15:0] c1_q    [2];
	logic [15:0] c2_q    [2];
	logic [15:0] plain_q [2];
	logic [15:0] sel_q   [2];
	sample_t     sgn_q   [2];
	ctl_t        ctl_q   [4];
	logic [4:0]  valid_sr;

	// Gain of A below the knee and a slope of 1/F above it
	function automatic logic [15:0] compress(logic [15:0] v, int x, int a, int f, int b);
		if (int'(v) < x)
			return 16'(int'(v) * a);
		return 16'(((int'(v) - x) / f) + b);
	endfunction

	always_comb begin
		in_ch[0] = beat_in.data.left;
		in_ch[1] = beat_in.data.right;
	end

	////////////////////
	// Magnitude and curves
	////////////////////

	always_ff @(posedge clk_sys) begin
		// Stage 1 takes magnitude and sign
		for (int ch = 0; ch < 2; ch++)
			mag_q[ch] <= in_ch[ch][15] ? 16'(-in_ch[ch]) : 16'(in_ch[ch]);
		ctl_q[0].boost <= beat_in.boost;
		ctl_q[0].vol_l <= beat_in.vol_master_l;
		ctl_q[0].vol_r <= beat_in.vol_master_r;
		ctl_q[0].sign  <= {in_ch[1][15], in_ch[0][15]};

		// Stage 2 forms both curves side by side
		for (int ch = 0; ch < 2; ch++) begin
			c1_q[ch]    <= compress(mag_q[ch], COMP_X1, int'(COMP_A1), int'(COMP_F1), COMP_B1);
			c2_q[ch]    <= compress(mag_q[ch], COMP_X2, int'(COMP_A2), int'(COMP_F2), COMP_B2);
			plain_q[ch] <= mag_q[ch];
		end
		ctl_q[1] <= ctl_q[0];

		// Stage 3 picks the curve for this frame
		for (int ch = 0; ch < 2; ch++) begin
			case (ctl_q[1].boost)
				BOOST_NONE: sel_q[ch] <= plain_q[ch];
				BOOST_2X:   sel_q[ch] <= c1_q[ch];
				default:    sel_q[ch] <= c2_q[ch];
			endcase
		end
		ctl_q[2] <= ctl_q[1];
	end

	////////////////////
	// Sign and master volume
	////////////////////

	always_ff @(posedge clk_sys) begin
		// Stage 4
		for (int ch = 0; ch < 2; ch++)
			sgn_q[ch] <= ctl_q[2].sign[ch] ? sample_t'(-sel_q[ch]) : sample_t'(sel_q[ch]);
		ctl_q[3] <= ctl_q[2];

		// Stage 5
		out.left  <= apply_volume(sgn_q[0], ctl_q[3].vol_l);
		out.right <= apply_volume(sgn_q[1], ctl_q[3].vol_r);
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[3:0], beat_in.valid};
	end

	assign out_stb = valid_sr[4];

endmodule

`default_nettype wire

// File: source/mix_clamp.sv
// Second pipeline stage that holds the 17-bit sum and saturates it to 16 bits
// Two cycles from beat_in to beat_out
`default_nettype none
`timescale 1ns/100ps

module mix_clamp (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  audio_pkg::scaled_beat_t beat_in,
	output audio_pkg::mixed_beat_t  beat_out
);

	import audio_pkg::*;

	scaled_beat_t sum_q;

	// Differing top two bits mean the sum left the 16-bit range
	function automatic sample_t saturate(sum_t s);
		if (s[16] != s[15])
			return s[16] ? sample_t'(-32768) : sample_t'(32767);
		return s[15:0];
	endfunction

	////////////////////
	// Sum register
	////////////////////

	always_ff @(posedge clk_sys) begin
		sum_q.left         <= beat_in.left;
		sum_q.right        <= beat_in.right;
		sum_q.boost        <= beat_in.boost;
		sum_q.vol_master_l <= beat_in.vol_master_l;
		sum_q.vol_master_r <= beat_in.vol_master_r;

		if (reset)
			sum_q.valid <= 1'b0;
		else
			sum_q.valid <= beat_in.valid;
	end

	////////////////////
	// Clamp register
	////////////////////

	always_ff @(posedge clk_sys) begin
		beat_out.data.left    <= saturate(sum_q.left);
		beat_out.data.right   <= saturate(sum_q.right);
		beat_out.boost        <= sum_q.boost;
		beat_out.vol_master_l <= sum_q.vol_master_l;
		beat_out.vol_master_r <= sum_q.vol_master_r;

		if (reset)
			beat_out.valid <= 1'b0;
		else
			beat_out.valid <= sum_q.valid;
	end

endmodule

`default_nettype wire

// File: source/source_scaler.sv
// First pipeline stage that scales each source and forms the raw stereo sum
// Captures sources and settings on in_stb
`default_nettype none
`timescale 1ns/100ps

module source_scaler (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      in_stb,
	input  audio_pkg::audio_sources_t sources,
	input  audio_pkg::mix_settings_t  settings,
	output audio_pkg::scaled_beat_t   beat
);

	import audio_pkg::*;

	logic [16:0] spk_term;
	sum_t        sum_l;
	sum_t        sum_r;

	// One channel of the mix before saturation
	function automatic sum_t side_sum(
		sample_t     sb,
		sample_t     cd,
		sample_t     midi,
		logic [16:0] spk,
		vol_t        vol_cd,
		logic        cd_en,
		vol_t        vol_midi,
		vol_t        vol_line,
		logic        line_en,
		logic        from_line,
		logic        mute
	);
		vol_t    midi_vol;
		sample_t midi_term;
		sample_t cd_term;

		// Synth level follows the line-in control when routed there
		midi_vol  = from_line ? (line_en ? vol_line : vol_t'(0)) : vol_midi;
		midi_term = mute ? sample_t'(0) : apply_volume(midi, midi_vol);
		cd_term   = cd_en ? apply_volume(cd, vol_cd) : sample_t'(0);

		return sum_t'(sb) + sum_t'(midi_term) + sum_t'(cd_term) + sum_t'(spk);
	endfunction

	////////////////////
	// Speaker level
	////////////////////

	// Boost moves the bit up and volume moves it back down
	always_comb begin
		spk_term = 17'(sources.speaker) << (5'd11 + 5'(settings.spk_boost));
		spk_term = spk_term >> (2'd3 - settings.vol_spk);
	end

	always_comb begin
		sum_l = side_sum(sources.sb.left, sources.cd.left, sources.midi.left, spk_term,
			settings.vol_cd_l, settings.cd_en_l, settings.vol_midi_l, settings.vol_line_l,
			settings.line_en_l, settings.midi_from_line, settings.midi_mute);
		sum_r = side_sum(sources.sb.right, sources.cd.right, sources.midi.right, spk_term,
			settings.vol_cd_r, settings.cd_en_r, settings.vol_midi_r, settings.vol_line_r,
			settings.line_en_r, settings.midi_from_line, settings.midi_mute);
	end

	////////////////////
	// Stage register
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (in_stb) begin
			beat.left         <= sum_l;
			beat.right        <= sum_r;
			// Later stages use the settings of their own frame
			beat.boost        <= settings.boost;
			beat.vol_master_l <= settings.vol_master_l;
			beat.vol_master_r <= settings.vol_master_r;
		end

		if (reset)
			beat.valid <= 1'b0;
		else
			beat.valid <= in_stb;
	end

endmodule

`default_nettype wire

// File: source/audio_pkg.sv
// Shared types and helpers for the audio output path
// Imported by every stage of the mixer pipeline
`default_nettype none

package audio_pkg;

	////////////////////
	// Sample types
	////////////////////

	// Signed 16-bit audio sample
	typedef logic signed [15:0] sample_t;

	// Sum of the scaled sources with one guard bit above a sample
	typedef logic signed [16:0] sum_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// Code zero is silent and the upper four bits give the level
	typedef logic [4:0] vol_t;

	// Code 3 is undefined and handled as 4x
	typedef enum logic [1:0] {
		BOOST_NONE = 2'd0,
		BOOST_2X   = 2'd1,
		BOOST_4X   = 2'd2
	} boost_mode_t;

	////////////////////
	// Frame and settings
	////////////////////

	typedef struct packed {
		stereo_t sb;
		stereo_t cd;
		stereo_t midi;
		logic    speaker;
	} audio_sources_t;

	typedef struct packed {
		vol_t        vol_master_l;
		vol_t        vol_master_r;
		vol_t        vol_cd_l;
		vol_t        vol_cd_r;
		vol_t        vol_midi_l;
		vol_t        vol_midi_r;
		vol_t        vol_line_l;
		vol_t        vol_line_r;
		logic [1:0]  vol_spk;
		logic [1:0]  spk_boost;
		logic        cd_en_l;
		logic        cd_en_r;
		logic        line_en_l;
		logic        line_en_r;
		logic        midi_from_line;
		logic        midi_mute;
		boost_mode_t boost;
	} mix_settings_t;

	////////////////////
	// Pipeline beats
	////////////////////

	// Raw sums from the scaler to the mixer with the settings later stages need
	typedef struct packed {
		logic        valid;
		sum_t        left;
		sum_t        right;
		boost_mode_t boost;
		vol_t        vol_master_l;
		vol_t        vol_master_r;
	} scaled_beat_t;

	// Saturated frame from the mixer to the leveler
	typedef struct packed {
		logic        valid;
		stereo_t     data;
		boost_mode_t boost;
		vol_t        vol_master_l;
		vol_t        vol_master_r;
	} mixed_beat_t;

	// Attenuates in 6 dB steps by 15 minus the level
	function automatic sample_t apply_volume(sample_t s, vol_t vol);
		if (vol == '0)
			return '0;
		return s >>> (4'd15 - vol[4:1]);
	endfunction

endpackage

`default_nettype wire
